//--- logic/werewolf_pkg.sv
package werewolf_pkg;

    // -------------------------------------------------------------------------
    // Game sizes
    // -------------------------------------------------------------------------
    localparam int NUM_SEATS = 5;                   // Players at the table
    localparam int SEAT_W    = 3;                   // Seat index width
    localparam int NUM_DEALS = 20;                  // Deals held in the ROM
    localparam int DEAL_W    = 5;                   // Deal index width

    // -------------------------------------------------------------------------
    // Roles
    // -------------------------------------------------------------------------
    typedef enum logic [1:0] {
        villager = 2'd0,                            // No night action
        wolf     = 2'd1,                            // Picks the victim
        doctor   = 2'd2,                            // Picks the protected seat
        no_role  = 2'd3                             // Shown outside a turn
    } role_t;

    // Locked deal, two bits per seat
    typedef union packed {
        logic [2*NUM_SEATS-1:0] raw;                // Word as stored in the ROM
        role_t [0:NUM_SEATS-1]  roles;              // Seat 0 in the top bits
    } role_word_u;

    // -------------------------------------------------------------------------
    // Game sequencer states
    // -------------------------------------------------------------------------
    typedef enum logic [3:0] {
        idle        = 4'd0,                         // Waiting for start
        clear_all   = 4'd1,                         // Wipe game state
        shuffle     = 4'd2,                         // Deal counter spins
        store_deal  = 4'd3,                         // Lock the role word
        night_start = 4'd4,                         // Back to seat 0
        wait_turn   = 4'd5,                         // Seat gets ready
        turn        = 4'd6,                         // Role shown, action taken
        next_seat   = 4'd7,                         // Advance seat counter
        check_alive = 4'd8,                         // Skip dead seats
        night_end   = 4'd9,
        resolve     = 4'd10,                        // Apply attack vs protect
        announce    = 4'd11                         // Result shown
    } game_state_t;

endpackage

//--- logic/game_ctrl_if.sv
interface game_ctrl_if;

    // Sequencer strobes, each a Moore level of one or more states
    logic clear_game;                               // Wipe deal, roles, deaths
    logic shuffle_step;                             // Advance deal counter
    logic store_deal;                               // Lock role word
    logic seat_clear;                               // Seat counter to 0
    logic seat_step;                                // Next seat, drop choice
    logic act_enable;                               // Turn in progress
    logic resolve_enable;                           // Settle the night

    // Datapath status
    logic last_seat;                                // Counter at final seat
    logic seat_alive;                               // Current seat not dead

    modport sequencer (
        output clear_game, shuffle_step, store_deal,
        output seat_clear, seat_step, act_enable, resolve_enable,
        input  last_seat, seat_alive
    );

    modport datapath (
        input  clear_game, shuffle_step, store_deal,
        input  seat_clear, seat_step, act_enable, resolve_enable,
        output last_seat, seat_alive
    );

endinterface

//--- logic/game_sequencer.sv
module game_sequencer
    import werewolf_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        start,                      // Begin a new game
    input  logic        pass,                       // Raw level
    game_ctrl_if.sequencer ctrl,
    output game_state_t state
);

    logic        pass_q0;                           // First sample of pass
    logic        pass_q1;                           // Previous sample
    logic        pass_pulse;                        // One cycle per press
    game_state_t cur_state;
    game_state_t next_state;

    // -------------------------------------------------------------------------
    // Pass edge detector
    // -------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pass_q0 <= 1'b0;
            pass_q1 <= 1'b0;
        end else begin
            pass_q0 <= pass;
            pass_q1 <= pass_q0;
        end
    end

    assign pass_pulse = pass_q0 & ~pass_q1;         // Rising edge only

    // -------------------------------------------------------------------------
    // State register
    // -------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cur_state <= idle;
        end else begin
            cur_state <= next_state;
        end
    end

    // -------------------------------------------------------------------------
    // Next state
    // -------------------------------------------------------------------------
    always_comb begin
        next_state = cur_state;                     // Hold by default
        case (cur_state)
            idle: begin
                if (start) next_state = clear_all;
            end
            clear_all:   next_state = shuffle;
            shuffle: begin
                if (pass_pulse) next_state = store_deal;    // Freeze the deal
            end
            store_deal:  next_state = night_start;
            // Seat 0 may already be dead, so it is checked like any other seat
            night_start: next_state = check_alive;
            wait_turn: begin
                if (pass_pulse) next_state = turn;
            end
            turn: begin
                if (pass_pulse) begin
                    if (ctrl.last_seat) begin
                        next_state = night_end;
                    end else begin
                        next_state = next_seat;
                    end
                end
            end
            next_seat:   next_state = check_alive;
            check_alive: begin
                if (ctrl.seat_alive) begin
                    next_state = wait_turn;
                end else if (ctrl.last_seat) begin
                    next_state = night_end;         // Dead last seat ends night
                end else begin
                    next_state = next_seat;         // Skip dead seat
                end
            end
            night_end:   next_state = resolve;
            resolve:     next_state = announce;
            announce: begin
                if (pass_pulse) next_state = night_start;   // Next night
            end
            default:     next_state = idle;         // Illegal code recovery
        endcase
    end

    // -------------------------------------------------------------------------
    // Moore strobes
    // -------------------------------------------------------------------------
    assign ctrl.clear_game     = (cur_state == idle) || (cur_state == clear_all);
    assign ctrl.shuffle_step   = (cur_state == shuffle);
    assign ctrl.store_deal     = (cur_state == store_deal);
    assign ctrl.seat_clear     = (cur_state == idle) || (cur_state == clear_all)
                              || (cur_state == night_start);
    assign ctrl.seat_step      = (cur_state == next_seat);      // Also drops choice
    assign ctrl.act_enable     = (cur_state == turn);
    assign ctrl.resolve_enable = (cur_state == resolve);

    assign state = cur_state;                       // Debug view of the phase

endmodule

//--- logic/deal_unit.sv
module deal_unit
    import werewolf_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  logic              clear_game,           // Back to deal 0
    input  logic              shuffle_step,         // Spin one position
    input  logic              store_deal,           // Lock current deal
    output logic [DEAL_W-1:0] deal_index,
    output role_word_u        role_word
);

    logic [DEAL_W-1:0]      deal_next;              // Counter value after edge
    logic [2*NUM_SEATS-1:0] rom_data;               // Word of deal_index

    // -------------------------------------------------------------------------
    // Shuffle counter, modulo NUM_DEALS
    // -------------------------------------------------------------------------
    always_comb begin
        deal_next = deal_index;
        if (clear_game) begin
            deal_next = '0;
        end else if (shuffle_step) begin
            if (deal_index == DEAL_W'(NUM_DEALS - 1)) begin
                deal_next = '0;                     // Wrap 19 to 0
            end else begin
                deal_next = deal_index + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            deal_index <= '0;
        end else begin
            deal_index <= deal_next;
        end
    end

    // -------------------------------------------------------------------------
    // Deal ROM
    // -------------------------------------------------------------------------
    // Addressed with the next count so the word always matches deal_index.
    // Wolf is seat i/4, doctor the (i mod 4)-th of the others, rest villagers.
    always_ff @(posedge clock) begin
        case (deal_next)
            5'd0:    rom_data <= 10'b01_10_00_00_00;    // Wolf 0, doctor 1
            5'd1:    rom_data <= 10'b01_00_10_00_00;    // Wolf 0, doctor 2
            5'd2:    rom_data <= 10'b01_00_00_10_00;    // Wolf 0, doctor 3
            5'd3:    rom_data <= 10'b01_00_00_00_10;    // Wolf 0, doctor 4
            5'd4:    rom_data <= 10'b10_01_00_00_00;    // Wolf 1, doctor 0
            5'd5:    rom_data <= 10'b00_01_10_00_00;    // Wolf 1, doctor 2
            5'd6:    rom_data <= 10'b00_01_00_10_00;    // Wolf 1, doctor 3
            5'd7:    rom_data <= 10'b00_01_00_00_10;    // Wolf 1, doctor 4
            5'd8:    rom_data <= 10'b10_00_01_00_00;    // Wolf 2, doctor 0
            5'd9:    rom_data <= 10'b00_10_01_00_00;    // Wolf 2, doctor 1
            5'd10:   rom_data <= 10'b00_00_01_10_00;    // Wolf 2, doctor 3
            5'd11:   rom_data <= 10'b00_00_01_00_10;    // Wolf 2, doctor 4
            5'd12:   rom_data <= 10'b10_00_00_01_00;    // Wolf 3, doctor 0
            5'd13:   rom_data <= 10'b00_10_00_01_00;    // Wolf 3, doctor 1
            5'd14:   rom_data <= 10'b00_00_10_01_00;    // Wolf 3, doctor 2
            5'd15:   rom_data <= 10'b00_00_00_01_10;    // Wolf 3, doctor 4
            5'd16:   rom_data <= 10'b10_00_00_00_01;    // Wolf 4, doctor 0
            5'd17:   rom_data <= 10'b00_10_00_00_01;    // Wolf 4, doctor 1
            5'd18:   rom_data <= 10'b00_00_10_00_01;    // Wolf 4, doctor 2
            5'd19:   rom_data <= 10'b00_00_00_10_01;    // Wolf 4, doctor 3
            default: rom_data <= 10'b01_10_00_00_00;    // Unreachable index
        endcase
    end

    // -------------------------------------------------------------------------
    // Locked role word
    // -------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            role_word <= '0;
        end else if (clear_game) begin
            role_word <= '0;                        // All villagers until dealt
        end else if (store_deal) begin
            role_word.raw <= rom_data;
        end
    end

endmodule

//--- logic/night_resolver.sv
module night_resolver
    import werewolf_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    game_ctrl_if.datapath        ctrl,
    input  role_word_u           role_word,         // Locked deal
    input  logic [NUM_SEATS-1:0] seat_buttons,      // Active high, one per seat
    output logic [SEAT_W-1:0]    seat,
    output role_t                seat_role,
    output logic [SEAT_W-1:0]    chosen,
    output logic [SEAT_W-1:0]    attacked,
    output logic [SEAT_W-1:0]    protected_seat,
    output logic [NUM_SEATS-1:0] deaths
);

    role_t cur_role;                                // Role of current seat

    // -------------------------------------------------------------------------
    // Seat counter and role lookup
    // -------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            seat <= '0;
        end else if (ctrl.seat_clear) begin
            seat <= '0;
        end else if (ctrl.seat_step) begin
            if (seat == SEAT_W'(NUM_SEATS - 1)) begin
                seat <= '0;                         // Wrap after last seat
            end else begin
                seat <= seat + 1'b1;
            end
        end
    end

    assign cur_role        = role_word.roles[seat];
    assign ctrl.last_seat  = (seat == SEAT_W'(NUM_SEATS - 1));
    assign ctrl.seat_alive = ~deaths[seat];
    assign seat_role       = ctrl.act_enable ? cur_role : no_role;     // Hidden off turn

    // -------------------------------------------------------------------------
    // Chosen-seat capture
    // -------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            chosen <= '0;
        end else if (ctrl.seat_clear || ctrl.seat_step) begin
            chosen <= '0;                           // Fresh choice per seat
        end else if (|seat_buttons) begin
            case (seat_buttons)
                5'b00001: chosen <= 3'd0;
                5'b00010: chosen <= 3'd1;
                5'b00100: chosen <= 3'd2;
                5'b01000: chosen <= 3'd3;
                5'b10000: chosen <= 3'd4;
                default:  chosen <= 3'd0;           // Several pressed
            endcase
        end
    end

    // -------------------------------------------------------------------------
    // Attack and protect registers
    // -------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            attacked       <= '0;
            protected_seat <= '0;
        end else if (ctrl.clear_game) begin
            attacked       <= '0;
            protected_seat <= '0;
        end else if (ctrl.act_enable) begin
            case (cur_role)
                wolf:    attacked       <= chosen;
                doctor:  protected_seat <= chosen;
                default: ;                          // Villager press ignored
            endcase
        end
    end

    // -------------------------------------------------------------------------
    // Death mask
    // -------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            deaths <= '0;
        end else if (ctrl.clear_game) begin
            deaths <= '0;
        end else if (ctrl.resolve_enable && (attacked != protected_seat)) begin
            deaths[attacked] <= 1'b1;               // Unprotected victim dies
        end
    end

endmodule

//--- logic/werewolf_top.sv
module werewolf_top
    import werewolf_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,             // New game request
    input  logic                 pass,              // Level, edge taken inside
    input  logic [NUM_SEATS-1:0] seat_buttons,      // One button per seat
    output game_state_t          state,
    output logic [DEAL_W-1:0]    deal_index,        // Shuffle position
    output logic [SEAT_W-1:0]    seat,              // Seat whose turn it is
    output role_t                seat_role,         // Role during a turn
    output logic [SEAT_W-1:0]    chosen,            // Last seat pressed
    output logic [SEAT_W-1:0]    attacked,          // Wolf's victim
    output logic [SEAT_W-1:0]    protected_seat,    // Doctor's pick
    output logic [NUM_SEATS-1:0] deaths             // One bit per dead seat
);

    game_ctrl_if ctrl_if ();                        // Sequencer to datapath

    role_word_u role_word;                          // Locked deal

    // -------------------------------------------------------------------------
    // Control
    // -------------------------------------------------------------------------
    game_sequencer sequencer_i (
        .clock (clock),
        .reset (reset),
        .start (start),
        .pass  (pass),
        .ctrl  (ctrl_if.sequencer),
        .state (state)
    );

    // -------------------------------------------------------------------------
    // Deal selection
    // -------------------------------------------------------------------------
    deal_unit deal_i (
        .clock        (clock),
        .reset        (reset),
        .clear_game   (ctrl_if.clear_game),
        .shuffle_step (ctrl_if.shuffle_step),
        .store_deal   (ctrl_if.store_deal),
        .deal_index   (deal_index),
        .role_word    (role_word)
    );

    // -------------------------------------------------------------------------
    // Night actions and deaths
    // -------------------------------------------------------------------------
    night_resolver resolver_i (
        .clock          (clock),
        .reset          (reset),
        .ctrl           (ctrl_if.datapath),
        .role_word      (role_word),
        .seat_buttons   (seat_buttons),
        .seat           (seat),
        .seat_role      (seat_role),
        .chosen         (chosen),
        .attacked       (attacked),
        .protected_seat (protected_seat),
        .deaths         (deaths)
    );

endmodule

//--- testbench/werewolf_assert.sv
module werewolf_assert
    import werewolf_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,
    input  game_state_t          state,
    input  logic [SEAT_W-1:0]    seat,
    input  role_t                seat_role,
    input  logic [NUM_SEATS-1:0] deaths
);

    // ------------------------------------------------------------------------
    // Sequencer entry
    // ------------------------------------------------------------------------
    idle_needs_start: assert property (
        @(posedge clock) disable iff (reset)
        (state == idle && !start) |=> (state == idle)     // No start, no game
    ) else $error("state left idle without start sampled high");

    // ------------------------------------------------------------------------
    // Death mask and turns
    // ------------------------------------------------------------------------
    deaths_only_grow: assert property (
        @(posedge clock) disable iff (reset)
        (state != clear_all) |=> ((deaths & $past(deaths)) == $past(deaths))
    ) else $error("deaths lost a bit outside clear_all");

    turn_seat_alive: assert property (
        @(posedge clock) disable iff (reset)
        (state == turn) |-> !deaths[seat]                 // Dead seats skipped
    ) else $error("dead seat holds a turn");

    role_hidden_off_turn: assert property (
        @(posedge clock) disable iff (reset)
        (state != turn) |-> (seat_role == no_role)
    ) else $error("seat_role shown outside a turn");

endmodule

bind werewolf_top werewolf_assert assert_i (
    .clock     (clock),
    .reset     (reset),
    .start     (start),
    .state     (state),
    .seat      (seat),
    .seat_role (seat_role),
    .deaths    (deaths)
);

//--- testbench/werewolf_tb.sv
module werewolf_tb
    import werewolf_pkg::*;
;

    localparam int CLOCK_PERIOD  = 4;
    localparam int NUM_ROWS      = 4;
    localparam int NIGHT_BOUND   = 150;             // Cycles for one full night
    localparam int SHUFFLE_BOUND = 80;              // 6 random bits plus margin
    localparam int SETUP_BOUND   = 100;             // Resets, start, new game
    localparam int WATCHDOG_CYCLES = NUM_ROWS * NIGHT_BOUND + SHUFFLE_BOUND + SETUP_BOUND;

    // Logical table seats with 0 the wolf, 1 the doctor and 2 to 4 the villagers in seat order
    typedef struct {
        string          name;
        int             victim;                     // Wolf's pick
        int             pick;                       // Doctor's pick
        logic [4:0]     mask;                       // Deaths after resolve
    } night_row_t;

    logic                 clock;
    logic                 reset;
    logic                 start;
    logic                 pass;
    logic [NUM_SEATS-1:0] seat_buttons;
    game_state_t          state;
    logic [DEAL_W-1:0]    deal_index;
    logic [SEAT_W-1:0]    seat;
    role_t                seat_role;
    logic [SEAT_W-1:0]    chosen;
    logic [SEAT_W-1:0]    attacked;
    logic [SEAT_W-1:0]    protected_seat;
    logic [NUM_SEATS-1:0] deaths;

    night_row_t  rows [NUM_ROWS];
    logic [31:0] lfsr_state;
    string       cur_test;
    int          deal;                              // Locked deal of this game
    int          check_count;
    int          error_count;

    werewolf_top dut_i (
        .clock          (clock),
        .reset          (reset),
        .start          (start),
        .pass           (pass),
        .seat_buttons   (seat_buttons),
        .state          (state),
        .deal_index     (deal_index),
        .seat           (seat),
        .seat_role      (seat_role),
        .chosen         (chosen),
        .attacked       (attacked),
        .protected_seat (protected_seat),
        .deaths         (deaths)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // ------------------------------------------------------------------------
    // Deal rule and random bits
    // ------------------------------------------------------------------------
    function automatic int doctor_seat(input int deal_no);
        int k;
        k = 0;
        for (int i = 0; i < NUM_SEATS; i++) begin
            if (i != deal_no / 4) begin             // Skip the wolf
                if (k == deal_no % 4) return i;
                k++;
            end
        end
        return 0;
    endfunction

    function automatic role_t expected_role(input int deal_no, input int s);
        if (s == deal_no / 4) return wolf;
        if (s == doctor_seat(deal_no)) return doctor;
        return villager;
    endfunction

    function automatic int physical_seat(input int deal_no, input int logical);
        int wolf_seat;
        int doc_seat;
        int k;
        wolf_seat = deal_no / 4;
        doc_seat  = doctor_seat(deal_no);
        k         = 2;                              // First villager slot
        if (logical == 0) return wolf_seat;
        if (logical == 1) return doc_seat;
        for (int i = 0; i < NUM_SEATS; i++) begin
            if (i != wolf_seat && i != doc_seat) begin
                if (k == logical) return i;
                k++;
            end
        end
        return 0;
    endfunction

    function automatic logic [4:0] map_mask(input int deal_no, input logic [4:0] logical_mask);
        logic [4:0] result;
        result = '0;
        for (int i = 0; i < NUM_SEATS; i++) begin
            if (logical_mask[i]) result[physical_seat(deal_no, i)] = 1'b1;
        end
        return result;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] value);
        if (value[0]) return (value >> 1) ^ 32'hA300_0000;
        return value >> 1;
    endfunction

    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);     // One step per bit
            value = (value << 1) | lfsr_state[0];
        end
    endtask

    // ------------------------------------------------------------------------
    // Checks and reporting
    // ------------------------------------------------------------------------
    task automatic check_value(input string what, input int expected, input int actual);
        check_count++;
        if (actual != expected) begin
            error_count++;
            $display("Mismatch %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        check_count++;
        error_count++;
        $display("Error in %s: %s", cur_test, msg);
    endtask

    task automatic report_test(input int first_error);
        $display("%-12s %s", cur_test, (error_count == first_error) ? "ok" : "failed");
    endtask

    task automatic check_idle();
        check_value("state", idle, state);
        check_value("deaths", 0, deaths);
        check_value("attacked", 0, attacked);
        check_value("protected_seat", 0, protected_seat);
        check_value("chosen", 0, chosen);
        check_value("deal_index", 0, deal_index);
        check_value("seat_role", no_role, seat_role);
    endtask

    // ------------------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------------------
    task automatic apply_reset();
        @(posedge clock);
        reset <= 1'b1;
        repeat (7) @(posedge clock);
        reset <= 1'b0;
    endtask

    task automatic wait_state(input game_state_t target);
        @(negedge clock);
        while (state != target) @(negedge clock);
    endtask

    task automatic pulse_pass();
        @(posedge clock);
        pass <= 1'b1;
        repeat (2) @(posedge clock);
        pass <= 1'b0;
        repeat (2) @(posedge clock);                // Edge detector rearms
    endtask

    task automatic press_button(input int target, input int hold);
        @(posedge clock);
        seat_buttons <= 5'b00001 << target;
        repeat (hold) @(posedge clock);
        seat_buttons <= '0;
        @(posedge clock);                           // Choice reaches registers
    endtask

    task automatic start_game();
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        wait_state(shuffle);
    endtask

    task automatic play_turn(input int r, input int exp_seat);
        int                s;
        int                target;
        int                hold;
        role_t             role;
        logic [SEAT_W-1:0] attacked_before;
        logic [SEAT_W-1:0] protected_before;
        pulse_pass();
        @(negedge clock);
        if (state != turn) report_failure("pass in wait_turn did not start a turn");
        s = exp_seat;
        check_value("seat", s, seat);
        if (deaths[seat]) report_failure($sformatf("dead seat %0d was given a turn", seat));
        role = expected_role(deal, s);
        check_value($sformatf("seat_role of seat %0d", s), role, seat_role);
        check_value("deal_index", deal, deal_index);
        attacked_before  = attacked;
        protected_before = protected_seat;
        if (role == wolf) begin
            target = physical_seat(deal, rows[r].victim);
        end else if (role == doctor) begin
            target = physical_seat(deal, rows[r].pick);
        end else begin
            take_bits(3, target);                   // Villager presses at random
            target = target % NUM_SEATS;
        end
        take_bits(2, hold);
        press_button(target, hold + 1);
        @(negedge clock);
        check_value("chosen", target, chosen);
        check_value("attacked", (role == wolf) ? target : attacked_before, attacked);
        check_value("protected_seat", (role == doctor) ? target : protected_before,
                    protected_seat);
        pulse_pass();
    endtask

    task automatic run_night(input int r);
        bit         done;
        int         exp_seat;                       // Next living seat in order
        logic [4:0] dead_before;                    // Deaths from earlier nights
        done     = 1'b0;
        exp_seat = 0;
        if (r == 0) begin
            dead_before = '0;
        end else begin
            dead_before = map_mask(deal, rows[r - 1].mask);
        end
        while (!done) begin
            @(negedge clock);
            while (state != wait_turn && state != announce) @(negedge clock);
            while (exp_seat < NUM_SEATS && dead_before[exp_seat]) exp_seat++;
            if (state == announce) begin
                if (exp_seat != NUM_SEATS) begin
                    report_failure($sformatf("night ended before seat %0d played", exp_seat));
                end
                done = 1'b1;
            end else begin
                play_turn(r, exp_seat);
                exp_seat++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int first_error;
        int shuffle_cycles;
        start        = 1'b0;
        pass         = 1'b0;
        seat_buttons = '0;
        reset        = 1'b1;
        lfsr_state   = 32'hfb80;
        check_count  = 0;
        error_count  = 0;
        rows[0] = '{"kill",        2, 3, 5'b00100};
        rows[1] = '{"save",        3, 3, 5'b00100};
        rows[2] = '{"second_kill", 4, 1, 5'b10100};
        rows[3] = '{"dead_victim", 2, 3, 5'b10100};

        apply_reset();
        cur_test    = "reset";
        first_error = error_count;
        @(negedge clock);
        check_idle();
        report_test(first_error);

        cur_test    = "deal";
        first_error = error_count;
        start_game();
        take_bits(6, shuffle_cycles);
        repeat (shuffle_cycles + 1) @(posedge clock);
        pulse_pass();                               // Freeze the deal
        wait_state(wait_turn);
        deal = (shuffle_cycles + 4) % NUM_DEALS;    // One step per shuffle cycle up to the pulse
        check_value("deal_index", deal, deal_index);
        report_test(first_error);

        for (int r = 0; r < NUM_ROWS; r++) begin
            cur_test    = rows[r].name;
            first_error = error_count;
            run_night(r);
            check_value("deaths", map_mask(deal, rows[r].mask), deaths);
            check_value("deal_index", deal, deal_index);
            report_test(first_error);
            pulse_pass();                           // On to the next night
        end

        cur_test    = "new_game";
        first_error = error_count;
        apply_reset();
        @(negedge clock);
        check_idle();
        start_game();
        check_value("deal_index", 0, deal_index);   // Shuffle restarts at 0
        check_value("deaths", 0, deaths);
        @(negedge clock);
        check_value("deal_index", 1, deal_index);
        report_test(first_error);

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- list.f
logic/werewolf_pkg.sv
logic/game_ctrl_if.sv
logic/game_sequencer.sv
logic/deal_unit.sv
logic/night_resolver.sv
logic/werewolf_top.sv
testbench/werewolf_assert.sv
testbench/werewolf_tb.sv
